//--- include/alu_engine_cfg.svh
`ifndef ALU_ENGINE_CFG_SVH
`define ALU_ENGINE_CFG_SVH

// ------------------------------------------------------------
// Packet geometry
// ------------------------------------------------------------

// Bits per memory field
`define ALU_FIELD_W 32

// Fields per packet, even so the output splits in two halves
`define ALU_NUM_FIELDS 4

`endif

//--- hw/alu_engine_pkg.sv
`default_nettype none

`include "alu_engine_cfg.svh"

package alu_engine_pkg;

  // ------------------------------------------------------------
  // Datapath vectors
  // ------------------------------------------------------------

  // One memory field
  typedef logic [`ALU_FIELD_W-1:0] field_t;

  // Whole packet, field 0 in the low slice
  typedef logic [`ALU_NUM_FIELDS*`ALU_FIELD_W-1:0] packet_t;

  // One bit per field, const mask and ALU pair mask
  typedef logic [`ALU_NUM_FIELDS-1:0] field_mask_t;

  // Bit i*N+j set means slot i reads input field j
  typedef logic [`ALU_NUM_FIELDS*`ALU_NUM_FIELDS-1:0] route_mask_t;

  // ------------------------------------------------------------
  // Encodings
  // ------------------------------------------------------------

  typedef enum logic [2:0] {
    ALU_NOP = 3'd0,
    ALU_ADD = 3'd1,
    ALU_SUB = 3'd2,
    ALU_MUL = 3'd3,
    ALU_ACC = 3'd4,
    ALU_DIV = 3'd5
  } alu_op_t;

  typedef enum logic {
    CTRL_UNCONFIGURED = 1'b0,
    CTRL_READY        = 1'b1
  } ctrl_state_t;

endpackage

`default_nettype wire

//--- hw/alu_engine_control.sv
`timescale 1ns/1ns
`default_nettype none

module alu_engine_control
  import alu_engine_pkg::*;
(
  input  logic        ap_clk,
  input  logic        areset,
  input  logic        clear,
  input  logic        config_load,
  input  alu_op_t     cfg_op,
  input  route_mask_t cfg_ops_mask,
  input  field_mask_t cfg_const_mask,
  input  field_t      cfg_const_value,
  input  field_mask_t cfg_alu_mask,
  input  logic        data_valid,
  output logic        sel_en,
  output logic        cmp_en,
  output logic        mrg_en,
  output logic        acc_clear,
  output alu_op_t     op,
  output route_mask_t ops_mask,
  output field_mask_t const_mask,
  output field_t      const_value,
  output field_mask_t alu_mask
);

  ctrl_state_t state;

  // ------------------------------------------------------------
  // Configuration registers
  // ------------------------------------------------------------

  always_ff @(posedge ap_clk) begin
    if (areset) begin
      op          <= ALU_NOP;
      ops_mask    <= '0;
      const_mask  <= '0;
      const_value <= '0;
      alu_mask    <= '0;
    end else if (config_load) begin
      op          <= cfg_op;
      ops_mask    <= cfg_ops_mask;
      const_mask  <= cfg_const_mask;
      const_value <= cfg_const_value;
      alu_mask    <= cfg_alu_mask;
    end
  end

  // First load arms the engine until the next reset
  always_ff @(posedge ap_clk) begin
    if (areset) begin
      state <= CTRL_UNCONFIGURED;
    end else if (config_load) begin
      state <= CTRL_READY;
    end
  end

  // ------------------------------------------------------------
  // Item valid tracking
  // ------------------------------------------------------------

  // One enable bit per stage, shifted every cycle
  always_ff @(posedge ap_clk) begin
    if (areset || clear) begin
      sel_en <= 1'b0;
      cmp_en <= 1'b0;
      mrg_en <= 1'b0;
    end else begin
      // Items before the first load are dropped here
      sel_en <= data_valid && (state == CTRL_READY);
      cmp_en <= sel_en;
      mrg_en <= cmp_en;
    end
  end

  // Accumulator is flushed together with the pipeline
  assign acc_clear = clear;

endmodule

`default_nettype wire

//--- hw/alu_operand_select.sv
`timescale 1ns/1ns
`default_nettype none

`include "alu_engine_cfg.svh"

module alu_operand_select
  import alu_engine_pkg::*;
(
  input  logic        ap_clk,
  input  logic        areset,
  input  logic        sel_en,
  input  packet_t     data,
  input  route_mask_t ops_mask,
  input  field_mask_t const_mask,
  input  field_t      const_value,
  output packet_t     operands,
  output packet_t     orig_fields
);

  localparam int N = `ALU_NUM_FIELDS;
  localparam int W = `ALU_FIELD_W;

  packet_t     data_q;
  field_mask_t route_hit;
  field_t      route_val [N];
  packet_t     operands_d;
  packet_t     orig_d;

  // Input capture, sel_en follows one cycle behind
  always_ff @(posedge ap_clk) begin
    data_q <= data;
  end

  // ------------------------------------------------------------
  // Routing, highest set bit of each row wins
  // ------------------------------------------------------------

  always_comb begin
    for (int i = 0; i < N; i++) begin
      route_hit[i] = 1'b0;
      route_val[i] = '0;
      for (int j = 0; j < N; j++) begin
        if (ops_mask[i*N+j]) begin
          route_hit[i] = 1'b1;
          route_val[i] = data_q[j*W +: W];
        end
      end
    end
  end

  always_comb begin
    for (int i = 0; i < N; i++) begin
      // Constant overrides the route, empty row reads as zero
      if (const_mask[i]) begin
        operands_d[i*W +: W] = const_value;
      end else if (route_hit[i]) begin
        operands_d[i*W +: W] = route_val[i];
      end else begin
        operands_d[i*W +: W] = '0;
      end

      // Original copy falls back to its own field
      orig_d[i*W +: W] = route_hit[i] ? route_val[i] : data_q[i*W +: W];
    end
  end

  always_ff @(posedge ap_clk) begin
    if (areset) begin
      operands    <= '0;
      orig_fields <= '0;
    end else if (sel_en) begin
      operands    <= operands_d;
      orig_fields <= orig_d;
    end
  end

endmodule

`default_nettype wire

//--- hw/alu_ops_compute.sv
`timescale 1ns/1ns
`default_nettype none

`include "alu_engine_cfg.svh"

module alu_ops_compute
  import alu_engine_pkg::*;
(
  input  logic        ap_clk,
  input  logic        areset,
  input  logic        cmp_en,
  input  logic        acc_clear,
  input  alu_op_t     op,
  input  field_mask_t alu_mask,
  input  packet_t     operands,
  input  packet_t     orig_fields,
  output field_t      alu_value,
  output logic        lower_pass,
  output packet_t     orig_fields_q,
  output packet_t     operands_q
);

  localparam int N = `ALU_NUM_FIELDS;
  localparam int W = `ALU_FIELD_W;

  field_t acc_q;
  logic   pair_hit;
  field_t pair_a;
  field_t pair_b;
  logic   acc_hit;
  field_t acc_in;
  field_t acc_sum;
  field_t value_d;
  logic   pass_d;

  // ------------------------------------------------------------
  // Pair index decode
  // ------------------------------------------------------------

  // Two-operand ops need a neighbour, so the top bit is not a pair
  always_comb begin
    pair_hit = 1'b0;
    pair_a   = '0;
    pair_b   = '0;
    for (int i = 0; i < N-1; i++) begin
      if (alu_mask[i]) begin
        pair_hit = 1'b1;
        pair_a   = operands[i*W +: W];
        pair_b   = operands[(i+1)*W +: W];
      end
    end
  end

  always_comb begin
    acc_hit = 1'b0;
    acc_in  = '0;
    for (int i = 0; i < N; i++) begin
      if (alu_mask[i]) begin
        acc_hit = 1'b1;
        acc_in  = operands[i*W +: W];
      end
    end
  end

  assign acc_sum = acc_q + acc_in;

  // ------------------------------------------------------------
  // Operation select
  // ------------------------------------------------------------

  always_comb begin
    value_d = '0;
    pass_d  = 1'b0;
    case (op)
      ALU_ADD: value_d = pair_hit ? field_t'(pair_a + pair_b) : '0;
      ALU_SUB: value_d = pair_hit ? field_t'(pair_a - pair_b) : '0;
      ALU_MUL: value_d = pair_hit ? field_t'(pair_a * pair_b) : '0;
      ALU_ACC: value_d = acc_hit ? acc_sum : '0;
      // NOP, DIV and unused codes hand the operands through
      default: pass_d = 1'b1;
    endcase
  end

  always_ff @(posedge ap_clk) begin
    if (areset || acc_clear) begin
      acc_q <= '0;
    end else if (cmp_en && (op == ALU_ACC) && acc_hit) begin
      acc_q <= acc_sum;
    end
  end

  // Operands and originals ride along with the result
  always_ff @(posedge ap_clk) begin
    if (cmp_en) begin
      alu_value     <= value_d;
      lower_pass    <= pass_d;
      orig_fields_q <= orig_fields;
      operands_q    <= operands;
    end
  end

endmodule

`default_nettype wire

//--- hw/alu_result_merge.sv
`timescale 1ns/1ns
`default_nettype none

`include "alu_engine_cfg.svh"

module alu_result_merge
  import alu_engine_pkg::*;
(
  input  logic    ap_clk,
  input  logic    areset,
  input  logic    clear,
  input  logic    mrg_en,
  input  field_t  alu_value,
  input  logic    lower_pass,
  input  packet_t operands_low,
  input  packet_t orig_fields_q,
  output logic    result_valid,
  output packet_t result
);

  localparam int N = `ALU_NUM_FIELDS;
  localparam int W = `ALU_FIELD_W;

  packet_t merged;

  always_comb begin
    merged = '0;
    // Lower half, ALU value in field 0 or the operands
    if (lower_pass) begin
      for (int i = 0; i < N/2; i++) begin
        merged[i*W +: W] = operands_low[i*W +: W];
      end
    end else begin
      merged[W-1:0] = alu_value;
    end
    // Upper half always carries the routed originals
    for (int i = N/2; i < N; i++) begin
      merged[i*W +: W] = orig_fields_q[i*W +: W];
    end
  end

  always_ff @(posedge ap_clk) begin
    if (areset || clear) begin
      result       <= '0;
      result_valid <= 1'b0;
    end else begin
      result_valid <= mrg_en;
      if (mrg_en) begin
        result <= merged;
      end
    end
  end

endmodule

`default_nettype wire

//--- hw/alu_engine_top.sv
`timescale 1ns/1ns
`default_nettype none

module alu_engine_top
  import alu_engine_pkg::*;
(
  input  logic        ap_clk,
  input  logic        areset,
  input  logic        clear,
  input  logic        config_load,
  input  alu_op_t     cfg_op,
  input  route_mask_t cfg_ops_mask,
  input  field_mask_t cfg_const_mask,
  input  field_t      cfg_const_value,
  input  field_mask_t cfg_alu_mask,
  input  logic        data_valid,
  input  packet_t     data,
  output logic        result_valid,
  output packet_t     result
);

  logic        sel_en;
  logic        cmp_en;
  logic        mrg_en;
  logic        acc_clear;
  alu_op_t     op;
  route_mask_t ops_mask;
  field_mask_t const_mask;
  field_t      const_value;
  field_mask_t alu_mask;
  packet_t     operands;
  packet_t     orig_fields;
  field_t      alu_value;
  logic        lower_pass;
  packet_t     orig_fields_q;
  packet_t     operands_q;

  // ------------------------------------------------------------
  // Control
  // ------------------------------------------------------------

  alu_engine_control i_control (
    .ap_clk          (ap_clk),
    .areset          (areset),
    .clear           (clear),
    .config_load     (config_load),
    .cfg_op          (cfg_op),
    .cfg_ops_mask    (cfg_ops_mask),
    .cfg_const_mask  (cfg_const_mask),
    .cfg_const_value (cfg_const_value),
    .cfg_alu_mask    (cfg_alu_mask),
    .data_valid      (data_valid),
    .sel_en          (sel_en),
    .cmp_en          (cmp_en),
    .mrg_en          (mrg_en),
    .acc_clear       (acc_clear),
    .op              (op),
    .ops_mask        (ops_mask),
    .const_mask      (const_mask),
    .const_value     (const_value),
    .alu_mask        (alu_mask)
  );

  // ------------------------------------------------------------
  // Datapath stages
  // ------------------------------------------------------------

  alu_operand_select i_select (
    .ap_clk      (ap_clk),
    .areset      (areset),
    .sel_en      (sel_en),
    .data        (data),
    .ops_mask    (ops_mask),
    .const_mask  (const_mask),
    .const_value (const_value),
    .operands    (operands),
    .orig_fields (orig_fields)
  );

  alu_ops_compute i_compute (
    .ap_clk        (ap_clk),
    .areset        (areset),
    .cmp_en        (cmp_en),
    .acc_clear     (acc_clear),
    .op            (op),
    .alu_mask      (alu_mask),
    .operands      (operands),
    .orig_fields   (orig_fields),
    .alu_value     (alu_value),
    .lower_pass    (lower_pass),
    .orig_fields_q (orig_fields_q),
    .operands_q    (operands_q)
  );

  alu_result_merge i_merge (
    .ap_clk        (ap_clk),
    .areset        (areset),
    .clear         (clear),
    .mrg_en        (mrg_en),
    .alu_value     (alu_value),
    .lower_pass    (lower_pass),
    .operands_low  (operands_q),
    .orig_fields_q (orig_fields_q),
    .result_valid  (result_valid),
    .result        (result)
  );

endmodule

`default_nettype wire

//--- verification/alu_engine_properties.sv
`timescale 1ns/1ns
`default_nettype none

module alu_engine_properties
  import alu_engine_pkg::*;
(
  input logic        ap_clk,
  input logic        areset,
  input logic        clear,
  input ctrl_state_t state,
  input logic        sel_en,
  input logic        cmp_en,
  input logic        mrg_en
);

  // ------------------------------------------------------------
  // Enable shift through the stages
  // ------------------------------------------------------------

  a_cmp_follows_sel: assert property (
    @(posedge ap_clk) disable iff (areset)
    !$past(clear) && !$past(areset) |-> cmp_en == $past(sel_en)
  ) else $error("cmp_en is not sel_en delayed by one cycle");

  a_mrg_follows_cmp: assert property (
    @(posedge ap_clk) disable iff (areset)
    !$past(clear) && !$past(areset) |-> mrg_en == $past(cmp_en)
  ) else $error("mrg_en is not cmp_en delayed by one cycle");

  // Nothing enters before the first configuration
  a_no_sel_unconfigured: assert property (
    @(posedge ap_clk) disable iff (areset)
    state == CTRL_UNCONFIGURED |-> !sel_en
  ) else $error("sel_en high while unconfigured");

  // Flush empties every stage
  a_clear_flushes: assert property (
    @(posedge ap_clk) disable iff (areset)
    clear |=> !sel_en && !cmp_en && !mrg_en
  ) else $error("enable still high in the cycle after clear");

endmodule

bind alu_engine_control alu_engine_properties i_properties (.*);

`default_nettype wire

//--- verification/alu_engine_tb.sv
`timescale 1ns/1ns
`default_nettype none

`include "alu_engine_cfg.svh"

module alu_engine_tb
  import alu_engine_pkg::*;
();

  localparam int N = `ALU_NUM_FIELDS;
  localparam int W = `ALU_FIELD_W;
  // Well above the length of all tests together
  localparam int TIMEOUT_CYCLES = 2000;

  logic        ap_clk;
  logic        areset;
  logic        clear;
  logic        config_load;
  alu_op_t     cfg_op;
  route_mask_t cfg_ops_mask;
  field_mask_t cfg_const_mask;
  field_t      cfg_const_value;
  field_mask_t cfg_alu_mask;
  logic        data_valid;
  packet_t     data;
  logic        result_valid;
  packet_t     result;

  integer seed = 32'h75ba_3607;
  int     cycle_cnt;
  int     error_cnt;
  int     check_cnt;

  // Model copy of the loaded configuration
  logic        m_ready;
  alu_op_t     m_op;
  route_mask_t m_route;
  field_mask_t m_cmask;
  field_t      m_cval;
  field_mask_t m_amask;
  field_t      m_acc;

  // Expected packets with the cycle each one is due
  packet_t exp_pkt_q[$];
  int      exp_due_q[$];

  alu_engine_top i_dut (
    .ap_clk          (ap_clk),
    .areset          (areset),
    .clear           (clear),
    .config_load     (config_load),
    .cfg_op          (cfg_op),
    .cfg_ops_mask    (cfg_ops_mask),
    .cfg_const_mask  (cfg_const_mask),
    .cfg_const_value (cfg_const_value),
    .cfg_alu_mask    (cfg_alu_mask),
    .data_valid      (data_valid),
    .data            (data),
    .result_valid    (result_valid),
    .result          (result)
  );

  initial ap_clk = 1'b0;
  always #2 ap_clk = ~ap_clk;

  always @(posedge ap_clk) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt >= TIMEOUT_CYCLES) begin
      $display("Timeout after %0d cycles with %0d results outstanding",
               cycle_cnt, exp_pkt_q.size());
      $display("Simulation FAILED");
      $finish;
    end
  end

  // ------------------------------------------------------------
  // Compare tasks
  // ------------------------------------------------------------

  task automatic check_packet(input string name, input packet_t got, input packet_t exp);
    check_cnt++;
    if (got !== exp) begin
      error_cnt++;
      $display("Error: %s got 0x%h expected 0x%h", name, got, exp);
    end
  endtask

  task automatic check_flag(input string name, input logic got, input logic exp);
    check_cnt++;
    if (got !== exp) begin
      error_cnt++;
      $display("Error: %s got 0x%h expected 0x%h", name, got, exp);
    end
  endtask

  // ------------------------------------------------------------
  // Reference model
  // ------------------------------------------------------------

  function automatic packet_t model_packet(input packet_t din);
    packet_t opnd;
    packet_t orig;
    packet_t pkt;
    field_t  value;
    field_t  a;
    field_t  b;
    logic    pass;
    int      pair_p;
    int      acc_p;
    opnd   = '0;
    orig   = din;
    pkt    = '0;
    value  = '0;
    a      = '0;
    b      = '0;
    pass   = 1'b0;
    pair_p = -1;
    acc_p  = -1;
    // Highest set bit of a row picks the field
    for (int i = 0; i < N; i++) begin
      for (int j = 0; j < N; j++) begin
        if (m_route[i*N+j]) begin
          opnd[i*W +: W] = din[j*W +: W];
          orig[i*W +: W] = din[j*W +: W];
        end
      end
      if (m_cmask[i]) begin
        opnd[i*W +: W] = m_cval;
      end
    end
    for (int i = 0; i < N; i++) begin
      if (m_amask[i]) begin
        acc_p = i;
        if (i < N-1) begin
          pair_p = i;
        end
      end
    end
    if (pair_p >= 0) begin
      a = opnd[pair_p*W +: W];
      b = opnd[(pair_p+1)*W +: W];
    end
    case (m_op)
      ALU_ADD: value = (pair_p >= 0) ? a + b : '0;
      ALU_SUB: value = (pair_p >= 0) ? a - b : '0;
      ALU_MUL: value = (pair_p >= 0) ? a * b : '0;
      ALU_ACC: begin
        if (acc_p >= 0) begin
          m_acc = m_acc + opnd[acc_p*W +: W];
          value = m_acc;
        end
      end
      // Divide behaves as pass
      default: pass = 1'b1;
    endcase
    for (int i = 0; i < N/2; i++) begin
      pkt[i*W +: W] = pass ? opnd[i*W +: W] : '0;
    end
    if (!pass) begin
      pkt[W-1:0] = value;
    end
    for (int i = N/2; i < N; i++) begin
      pkt[i*W +: W] = orig[i*W +: W];
    end
    return pkt;
  endfunction

  function automatic packet_t random_packet();
    packet_t p;
    for (int i = 0; i < N; i++) begin
      p[i*W +: W] = $random(seed);
    end
    return p;
  endfunction

  function automatic route_mask_t route_bit(input int slot, input int field);
    route_mask_t r;
    r = '0;
    r[slot*N+field] = 1'b1;
    return r;
  endfunction

  // Results compared in order on their due cycles
  always @(negedge ap_clk) begin
    if (!areset) begin
      if (result_valid) begin
        if (exp_pkt_q.size() == 0) begin
          error_cnt++;
          $display("Unexpected result at cycle %0d with no item outstanding", cycle_cnt);
        end else begin
          if (exp_due_q[0] != cycle_cnt) begin
            error_cnt++;
            $display("Result arrived at cycle %0d but was due at cycle %0d",
                     cycle_cnt, exp_due_q[0]);
          end
          check_packet("result", result, exp_pkt_q.pop_front());
          void'(exp_due_q.pop_front());
        end
      end else if (exp_pkt_q.size() != 0 && exp_due_q[0] <= cycle_cnt) begin
        error_cnt++;
        $display("No result for the item due at cycle %0d", exp_due_q[0]);
        void'(exp_pkt_q.pop_front());
        void'(exp_due_q.pop_front());
      end
    end
  end

  // ------------------------------------------------------------
  // Driver tasks starting and ending on a falling edge
  // ------------------------------------------------------------

  task automatic reset_dut();
    areset = 1'b1;
    repeat (3) @(posedge ap_clk);
    @(negedge ap_clk);
    areset = 1'b0;
  endtask

  task automatic load_config(input alu_op_t op, input route_mask_t route,
                             input field_mask_t cmask, input field_t cval,
                             input field_mask_t amask);
    config_load     = 1'b1;
    cfg_op          = op;
    cfg_ops_mask    = route;
    cfg_const_mask  = cmask;
    cfg_const_value = cval;
    cfg_alu_mask    = amask;
    m_op            = op;
    m_route         = route;
    m_cmask         = cmask;
    m_cval          = cval;
    m_amask         = amask;
    m_ready         = 1'b1;
    @(negedge ap_clk);
    config_load = 1'b0;
  endtask

  task automatic send_item(input packet_t d);
    data_valid = 1'b1;
    data       = d;
    if (m_ready) begin
      exp_pkt_q.push_back(model_packet(d));
      exp_due_q.push_back(cycle_cnt + 4);
    end
    @(negedge ap_clk);
  endtask

  task automatic drain();
    data_valid = 1'b0;
    while (exp_pkt_q.size() != 0) begin
      @(negedge ap_clk);
    end
    @(negedge ap_clk);
  endtask

  task automatic pulse_clear();
    data_valid = 1'b0;
    clear      = 1'b1;
    @(posedge ap_clk);
    // Flush drops whatever is still in the pipe
    exp_pkt_q.delete();
    exp_due_q.delete();
    m_acc = '0;
    @(negedge ap_clk);
    clear = 1'b0;
    check_flag("result_valid", result_valid, 1'b0);
    check_packet("result", result, '0);
  endtask

  // ------------------------------------------------------------
  // Directed tests
  // ------------------------------------------------------------

  task automatic test_unconfigured();
    for (int i = 0; i < 4; i++) begin
      check_flag("result_valid", result_valid, 1'b0);
      send_item(random_packet());
    end
    data_valid = 1'b0;
    repeat (5) begin
      check_flag("result_valid", result_valid, 1'b0);
      @(negedge ap_clk);
    end
  endtask

  task automatic test_arith();
    alu_op_t     ops [3];
    route_mask_t route;
    field_mask_t amask;
    ops = '{ALU_ADD, ALU_SUB, ALU_MUL};
    for (int k = 0; k < 3; k++) begin
      route = route_mask_t'($random(seed));
      amask = field_mask_t'($random(seed));
      // Keep a usable pair in the mask
      if (amask[N-2:0] == '0) begin
        amask[0] = 1'b1;
      end
      load_config(ops[k], route, '0, '0, amask);
      for (int i = 0; i < 20; i++) begin
        send_item(random_packet());
      end
      drain();
    end
  endtask

  task automatic test_pass();
    route_mask_t route;
    // Row 1 empty and row 3 with two bits
    route = route_bit(0, 2) | route_bit(2, 3) | route_bit(3, 0) | route_bit(3, 1);
    load_config(ALU_NOP, route, 4'b0100, 32'hcafe_0001, 4'b0001);
    for (int i = 0; i < 4; i++) begin
      send_item(random_packet());
    end
    drain();
    // Rows 1 and 3 empty so field 3 keeps its own input
    route = route_bit(0, 2) | route_bit(2, 0);
    load_config(ALU_DIV, route, 4'b0001, 32'h1234_abcd, 4'b0011);
    for (int i = 0; i < 4; i++) begin
      send_item(random_packet());
    end
    drain();
  endtask

  task automatic test_accumulate();
    route_mask_t route;
    route = route_bit(0, 0) | route_bit(1, 1) | route_bit(2, 2) | route_bit(3, 3);
    load_config(ALU_ACC, route, '0, '0, 4'b0100);
    for (int i = 0; i < 6; i++) begin
      send_item(random_packet());
    end
    drain();
    for (int i = 0; i < 3; i++) begin
      send_item(random_packet());
    end
    pulse_clear();
    for (int i = 0; i < 4; i++) begin
      send_item(random_packet());
    end
    drain();
  endtask

  task automatic test_reload();
    route_mask_t route;
    route = route_bit(0, 1) | route_bit(1, 3) | route_bit(2, 0) | route_bit(3, 2);
    load_config(ALU_ADD, route, '0, '0, 4'b0001);
    for (int i = 0; i < 5; i++) begin
      send_item(random_packet());
    end
    drain();
    load_config(ALU_SUB, route, 4'b0010, 32'h0000_0100, 4'b0001);
    for (int i = 0; i < 5; i++) begin
      send_item(random_packet());
    end
    drain();
    // Top field alone has no neighbour
    load_config(ALU_ADD, route, '0, '0, 4'b1000);
    for (int i = 0; i < 3; i++) begin
      send_item(random_packet());
    end
    drain();
    load_config(ALU_ACC, route, '0, '0, 4'b0000);
    for (int i = 0; i < 3; i++) begin
      send_item(random_packet());
    end
    drain();
  endtask

  initial begin
    cycle_cnt       = 0;
    error_cnt       = 0;
    check_cnt       = 0;
    areset          = 1'b1;
    clear           = 1'b0;
    config_load     = 1'b0;
    cfg_op          = ALU_NOP;
    cfg_ops_mask    = '0;
    cfg_const_mask  = '0;
    cfg_const_value = '0;
    cfg_alu_mask    = '0;
    data_valid      = 1'b0;
    data            = '0;
    m_ready         = 1'b0;
    m_op            = ALU_NOP;
    m_route         = '0;
    m_cmask         = '0;
    m_cval          = '0;
    m_amask         = '0;
    m_acc           = '0;
    reset_dut();
    test_unconfigured();
    test_arith();
    test_pass();
    test_accumulate();
    test_reload();
    drain();
    $display("Checks: %0d, errors: %0d", check_cnt, error_cnt);
    if (error_cnt == 0) begin
      $display("Simulation PASSED");
    end else begin
      $display("Simulation FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- sources.f
+incdir+include
hw/alu_engine_pkg.sv
hw/alu_engine_control.sv
hw/alu_operand_select.sv
hw/alu_ops_compute.sv
hw/alu_result_merge.sv
hw/alu_engine_top.sv
verification/alu_engine_properties.sv
verification/alu_engine_tb.sv
